// ==== build.f ====
logic/rv32i_fetch_pkg.sv
logic/fetch_stage.sv
logic/branch_predictor.sv
logic/hazard_unit.sv
logic/wb_ifetch_master.sv
logic/fetch_unit_top.sv
bench/imem_model.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

  localparam int NROWS = 10;

  logic CLK, nRST, npc_sel, insert_priv_pc, if_ex_stall_in, if_ex_flush_in;
  logic upd_en, upd_taken;
  logic [31:0] brj_addr, priv_pc, upd_pc, upd_target;
  logic wb_cyc, wb_stb, wb_ack, token, ex_prediction, mal_insn;
  logic [31:0] wb_adr, wb_dat_i, ex_pc, ex_pc4, ex_instr, badaddr_f, epc_f;
  int   tok_count;
  int   err_count;
  int   mal_seen;
  int   other_errors = 0;
  int   base;

  // kind bit 0 is a branch pulse, bit 1 a privileged pulse, both may fire together
  string       row_name [NROWS];
  int          row_kind [NROWS];
  logic [31:0] row_brj [NROWS];
  logic [31:0] row_priv [NROWS];
  logic        row_upd [NROWS];
  logic [31:0] row_upd_pc [NROWS];
  logic        row_upd_taken [NROWS];
  logic [31:0] row_upd_tgt [NROWS];
  int          row_stall [NROWS];
  logic        row_flush [NROWS];
  int          row_ntok [NROWS];

  fetch_unit_top uut (.*);

  imem_model imem (.CLK, .nRST, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat_i);

  fetch_checker chk (
    .CLK, .nRST, .npc_sel, .brj_addr, .insert_priv_pc, .priv_pc, .if_ex_stall_in,
    .if_ex_flush_in, .upd_en, .upd_pc, .upd_taken, .upd_target, .wb_cyc, .wb_stb,
    .wb_adr, .wb_ack, .token, .ex_pc, .ex_pc4, .ex_instr, .ex_prediction, .mal_insn,
    .badaddr_f, .epc_f, .tok_count, .err_count, .mal_seen
  );

  task automatic set_row(input int r, input string n, input int k, input logic [31:0] b,
                         input logic [31:0] p, input logic ue, input logic [31:0] upc,
                         input logic ut, input logic [31:0] utg, input int s,
                         input logic f, input int nt);
    row_name[r]      = n;
    row_kind[r]      = k;
    row_brj[r]       = b;
    row_priv[r]      = p;
    row_upd[r]       = ue;
    row_upd_pc[r]    = upc;
    row_upd_taken[r] = ut;
    row_upd_tgt[r]   = utg;
    row_stall[r]     = s;
    row_flush[r]     = f;
    row_ntok[r]      = nt;
  endtask

  // one drive slot, 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  // park in the drive slot of a cycle in which the slave acks
  task automatic wait_for_ack();
    while (!wb_ack) begin
      next_cycle();
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    #((NROWS * 40 + 10) * 4);
    $display("timeout: the fetch unit stopped delivering tokens");
    $display("Errors found");
    $finish;
  end

  initial begin
    set_row(0, "sequential", 0, 0, 0, 0, 0, 0, 0, 0, 0, 6);
    set_row(1, "branch", 1, 32'h400, 0, 0, 0, 0, 0, 0, 0, 4);
    set_row(2, "priv_wins", 3, 32'h500, 32'h600, 0, 0, 0, 0, 0, 0, 4);
    set_row(3, "train_taken", 1, 32'h638, 0, 1, 32'h640, 1, 32'h700, 0, 0, 5);
    set_row(4, "train_nt_1", 1, 32'h638, 0, 1, 32'h640, 0, 32'h700, 0, 0, 4);
    set_row(5, "train_nt_2", 1, 32'h63c, 0, 1, 32'h640, 0, 32'h700, 0, 0, 3);
    set_row(6, "stall", 0, 0, 0, 0, 0, 0, 0, 5, 0, 4);
    set_row(7, "flush", 0, 0, 0, 0, 0, 0, 0, 0, 1, 4);
    set_row(8, "misaligned", 2, 0, 32'h302, 0, 0, 0, 0, 0, 0, 3);
    set_row(9, "realign", 1, 32'h200, 0, 0, 0, 0, 0, 0, 0, 3);
    nRST           = 1'b0;
    npc_sel        = 1'b0;
    insert_priv_pc = 1'b0;
    if_ex_stall_in = 1'b0;
    if_ex_flush_in = 1'b0;
    upd_en         = 1'b0;
    upd_taken      = 1'b0;
    brj_addr       = '0;
    priv_pc        = '0;
    upd_pc         = '0;
    upd_target     = '0;
    repeat (5) @(posedge CLK);
    #1 nRST = 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      chk.test_name = row_name[r];
      if (row_upd[r]) begin
        upd_en     = 1'b1;
        upd_pc     = row_upd_pc[r];
        upd_taken  = row_upd_taken[r];
        upd_target = row_upd_tgt[r];
        next_cycle();
        upd_en = 1'b0;
      end
      if (row_kind[r] != 0) begin
        npc_sel        = row_kind[r][0];
        insert_priv_pc = row_kind[r][1];
        brj_addr       = row_brj[r];
        priv_pc        = row_priv[r];
        next_cycle();
        npc_sel        = 1'b0;
        insert_priv_pc = 1'b0;
      end
      if (row_stall[r] > 0) begin
        wait_for_ack();  // the stall starts on an ack so the master has to keep the word
        if_ex_stall_in = 1'b1;
        repeat (row_stall[r]) begin
          next_cycle();
        end
        if_ex_stall_in = 1'b0;
      end
      if (row_flush[r]) begin
        wait_for_ack();  // the flushed cycle carries a real word
        if_ex_flush_in = 1'b1;
        next_cycle();
        if_ex_flush_in = 1'b0;
      end
      base = tok_count;
      while (tok_count < base + row_ntok[r]) begin
        next_cycle();
      end
    end
    if (mal_seen == 0) begin
      $display("the misaligned redirect never raised mal_insn");
      other_errors++;
    end
    $display("tokens checked %0d, checker errors %0d, other errors %0d",
             tok_count, err_count, other_errors);
    if (err_count == 0 && other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== bench/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        npc_sel,
  input  logic [31:0] brj_addr,
  input  logic        insert_priv_pc,
  input  logic [31:0] priv_pc,
  input  logic        if_ex_stall_in,
  input  logic        if_ex_flush_in,
  input  logic        upd_en,
  input  logic [31:0] upd_pc,
  input  logic        upd_taken,
  input  logic [31:0] upd_target,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic [31:0] wb_adr,
  input  logic        wb_ack,
  input  logic        token,
  input  logic [31:0] ex_pc,
  input  logic [31:0] ex_pc4,
  input  logic [31:0] ex_instr,
  input  logic        ex_prediction,
  input  logic        mal_insn,
  input  logic [31:0] badaddr_f,
  input  logic [31:0] epc_f,
  output int          tok_count,
  output int          err_count,
  output int          mal_seen
);

  string       test_name = "reset";
  logic [31:0] exp_pc = 32'h200;  // pc the next real token must carry
  logic [31:0] last_redirect = '0;
  logic        prev_stall = 1'b0;
  logic        prev_flush = 1'b0;
  logic        prev_mal = 1'b0;
  logic        prev_req = 1'b0;  // a read was on the bus without ack last cycle
  logic        prev_ack = 1'b0;
  logic [31:0] prev_adr;
  logic        snap_token;
  logic [31:0] snap_pc;
  logic [31:0] snap_pc4;
  logic [31:0] snap_instr;
  logic        snap_pred;
  logic        train_pend = 1'b0;  // training seen last cycle, lands after this check
  logic [31:0] tr_pc;
  logic [31:0] tr_target;
  logic        tr_taken;
  // reference btb, 16 entries, two-bit counters with 2 and 3 meaning taken
  logic        m_valid [16];
  logic [25:0] m_tag [16];
  logic [31:0] m_target [16];
  int          m_cnt [16];

  initial begin
    tok_count = 0;
    err_count = 0;
    mal_seen  = 0;
    for (int i = 0; i < 16; i++) begin
      m_valid[i] = 1'b0;
    end
  end

  function automatic logic [31:0] expected_instr(input logic [31:0] a);
    logic [31:0] w;
    w = {a[15:0] ^ 16'hA5A5, a[15:0]};
    return {w[7:0], w[15:8], w[23:16], w[31:24]};  // big endian for the decoder
  endfunction

  function automatic logic predicts(input logic [31:0] a);
    return m_valid[a[5:2]] && m_tag[a[5:2]] == a[31:6] && m_cnt[a[5:2]] >= 2;
  endfunction

  task automatic train_btb();
    int i;
    i = tr_pc[5:2];
    if (!(m_valid[i] && m_tag[i] == tr_pc[31:6])) begin
      m_cnt[i] = tr_taken ? 2 : 1;  // new owner starts weak
    end else if (tr_taken) begin
      m_cnt[i] = (m_cnt[i] < 3) ? m_cnt[i] + 1 : 3;
    end else begin
      m_cnt[i] = (m_cnt[i] > 0) ? m_cnt[i] - 1 : 0;
    end
    m_valid[i]  = 1'b1;
    m_tag[i]    = tr_pc[31:6];
    m_target[i] = tr_target;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] e, input logic [31:0] a);
    $display("MISMATCH %s %s: expected %h actual %h", test_name, what, e, a);
    err_count++;
  endtask

  task automatic report_bus(input string what);
    $display("%s: %s", test_name, what);
    err_count++;
  endtask

  // inputs and outputs are both settled at the falling edge
  always @(negedge CLK) begin
    if (nRST) begin
      if (prev_stall) begin
        // a stalled register must not move at all
        if (token !== snap_token) report_mismatch("held token", snap_token, token);
        if (ex_pc !== snap_pc) report_mismatch("held pc", snap_pc, ex_pc);
        if (ex_pc4 !== snap_pc4) report_mismatch("held pc4", snap_pc4, ex_pc4);
        if (ex_instr !== snap_instr) report_mismatch("held instr", snap_instr, ex_instr);
        if (ex_prediction !== snap_pred) begin
          report_mismatch("held prediction", snap_pred, ex_prediction);
        end
      end else if (token) begin
        if (ex_pc !== exp_pc) report_mismatch("pc", exp_pc, ex_pc);
        if (ex_pc4 !== exp_pc + 32'd4) report_mismatch("pc4", exp_pc + 32'd4, ex_pc4);
        if (ex_instr !== expected_instr(exp_pc)) begin
          report_mismatch("instr", expected_instr(exp_pc), ex_instr);
        end
        if (ex_prediction !== predicts(exp_pc)) begin
          report_mismatch("prediction", predicts(exp_pc), ex_prediction);
        end
        exp_pc = predicts(exp_pc) ? m_target[exp_pc[5:2]] : exp_pc + 32'd4;
        tok_count++;
      end
      if (prev_flush && token !== 1'b0) begin  // the flushed word must come out as a bubble
        report_mismatch("flushed token", 32'd0, token);
      end
      if (mal_insn && !prev_mal) begin  // first cycle on a misaligned pc
        mal_seen++;
        if (badaddr_f !== last_redirect) report_mismatch("badaddr", last_redirect, badaddr_f);
        if (epc_f !== last_redirect) report_mismatch("epc", last_redirect, epc_f);
      end
      // classic read, cyc and stb move together and stay put until the ack
      if (wb_stb !== wb_cyc) begin
        report_bus("wb_stb and wb_cyc are not raised and dropped together");
      end
      if (prev_req && !(wb_stb && wb_adr === prev_adr)) begin
        report_bus("the master dropped stb or moved the address before the ack");
      end
      if (prev_ack && wb_stb) begin
        report_bus("stb did not drop for one cycle after an ack");
      end
      prev_req = wb_stb && !wb_ack;
      prev_ack = wb_ack;
      prev_adr = wb_adr;
      if (train_pend) train_btb();
      train_pend = upd_en;
      tr_pc      = upd_pc;
      tr_taken   = upd_taken;
      tr_target  = upd_target;
      // a redirect on the coming edge replaces whatever the path would have been
      if (insert_priv_pc) begin
        exp_pc        = priv_pc;
        last_redirect = priv_pc;
      end else if (npc_sel) begin
        exp_pc        = brj_addr;
        last_redirect = brj_addr;
      end
      prev_stall = if_ex_stall_in;
      prev_flush = if_ex_flush_in;
      prev_mal   = mal_insn;
      snap_token = token;
      snap_pc    = ex_pc;
      snap_pc4   = ex_pc4;
      snap_instr = ex_instr;
      snap_pred  = ex_prediction;
    end
  end

endmodule

// ==== bench/imem_model.sv ====
`timescale 1ns/1ps

module imem_model (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic [31:0] wb_adr,
  output logic        wb_ack,
  output logic [31:0] wb_dat_i  // named from the master's side
);

  integer seed = 27639;  // fixed so every run sees the same wait states
  int     wait_cnt;      // cycles left before the next ack

  // every word is a function of its address so any read can be checked
  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {a[15:0] ^ 16'hA5A5, a[15:0]};
  endfunction

  // 0 to 3 extra cycles drawn per read
  function automatic int draw_wait();
    int r;
    r = $random(seed);
    if (r < 0) begin
      r = -r;
    end
    return r % 4;
  endfunction

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wb_ack   <= 1'b0;
      wb_dat_i <= '0;
      wait_cnt <= draw_wait();
    end else if (wb_ack) begin
      wb_ack   <= 1'b0;  // one ack per classic cycle
      wait_cnt <= draw_wait();
    end else if (wb_cyc && wb_stb) begin
      if (wait_cnt == 0) begin
        wb_ack   <= 1'b1;
        wb_dat_i <= word_at(wb_adr);
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

// ==== logic/fetch_unit_top.sv ====
`timescale 1ns/1ps

module fetch_unit_top import rv32i_fetch_pkg::*; #(
  parameter addr_t RESET_PC    = 32'h200,  // first fetch after reset
  parameter int    BTB_ENTRIES = 16        // btb depth, tied to btb_idx_t
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  wb_ack,
  input  word_t wb_dat_i,
  input  logic  npc_sel,         // execute branch or jump redirect
  input  addr_t brj_addr,
  input  logic  insert_priv_pc,  // trap entry or return redirect
  input  addr_t priv_pc,
  input  logic  if_ex_stall_in,
  input  logic  if_ex_flush_in,
  input  logic  upd_en,          // btb training from execute
  input  addr_t upd_pc,
  input  logic  upd_taken,
  input  addr_t upd_target,
  output logic  wb_cyc,
  output logic  wb_stb,
  output addr_t wb_adr,
  output logic  token,           // fetch/execute register, token low is a bubble
  output addr_t ex_pc,
  output addr_t ex_pc4,
  output word_t ex_instr,
  output logic  ex_prediction,
  output logic  mal_insn,        // misaligned fetch exception
  output addr_t badaddr_f,
  output addr_t epc_f
);

  // fetch stage to and from the bus master
  addr_t fetch_addr;
  logic  fetch_ack;
  logic  fetch_busy;
  word_t fetch_data;

  // fetch stage to and from the btb
  addr_t lookup_pc;
  logic  predict_taken;
  addr_t predict_target;

  // hazard unit decisions
  logic  pc_en;
  logic  pc_sel;
  addr_t redirect_pc;
  logic  if_ex_stall;
  logic  if_ex_flush;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .CLK, .nRST, .pc_en, .pc_sel, .redirect_pc, .predict_taken, .predict_target,
    .fetch_ack, .fetch_data, .if_ex_stall, .if_ex_flush, .fetch_addr, .lookup_pc,
    .token, .ex_pc, .ex_pc4, .ex_instr, .ex_prediction, .mal_insn, .badaddr_f, .epc_f
  );

  branch_predictor #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) u_btb (
    .CLK, .nRST, .lookup_pc, .upd_en, .upd_pc, .upd_taken, .upd_target,
    .predict_taken, .predict_target
  );

  hazard_unit u_hazard (
    .CLK, .nRST, .fetch_ack, .fetch_busy, .npc_sel, .brj_addr, .insert_priv_pc, .priv_pc,
    .if_ex_stall_in, .if_ex_flush_in, .pc_en, .pc_sel, .redirect_pc, .if_ex_stall, .if_ex_flush
  );

  // the master keeps an acked word while execute is stalled
  wb_ifetch_master u_wb (
    .CLK, .nRST, .fetch_addr, .hold(if_ex_stall), .wb_ack, .wb_dat_i,
    .wb_cyc, .wb_stb, .wb_adr, .fetch_ack, .fetch_busy, .fetch_data
  );

endmodule

// ==== logic/wb_ifetch_master.sv ====
`timescale 1ns/1ps

module wb_ifetch_master import rv32i_fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  addr_t fetch_addr,  // current pc, stable for the whole read
  input  logic  hold,        // execute stalled, keep the word instead of handing it over
  input  logic  wb_ack,
  input  word_t wb_dat_i,
  output logic  wb_cyc,
  output logic  wb_stb,
  output addr_t wb_adr,
  output logic  fetch_ack,   // a word for fetch_addr is on fetch_data
  output logic  fetch_busy,  // a read is out on the bus
  output word_t fetch_data
);

  typedef enum logic {
    idle,     // between reads, or sitting on a held word
    wait_ack  // cyc and stb up, waiting for the slave
  } wb_state_t;

  wb_state_t state;
  logic      held;    // word_q carries an acked word nobody has taken yet
  word_t     word_q;  // copy of the read data kept across a stall

  // one classic read per pass through wait_ack, cyc and stb rise and fall together
  assign wb_cyc     = (state == wait_ack);
  assign wb_stb     = (state == wait_ack);
  assign wb_adr     = fetch_addr;  // the pc cannot move before the ack
  assign fetch_busy = (state == wait_ack);

  // live data on the ack cycle, the saved copy while it is being re-presented
  assign fetch_ack  = (wb_cyc & wb_ack) | held;
  assign fetch_data = held ? word_q : wb_dat_i;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= idle;
      held  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (!held || !hold) begin
            state <= wait_ack;  // next read starts after exactly one idle cycle
            held  <= 1'b0;      // a held word is taken on this edge
          end
        end
        wait_ack: begin
          if (wb_ack) begin
            state <= idle;  // drop stb for a cycle before the next read
            held  <= hold;  // stalled, so keep the word and offer it again
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // the saved word is payload only, it is qualified by held
  always_ff @(posedge CLK) begin
    if (wb_cyc && wb_ack && hold) begin
      word_q <= wb_dat_i;
    end
  end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import rv32i_fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  fetch_ack,       // a fetched word is on offer this cycle
  input  logic  fetch_busy,      // a wishbone read is in flight
  input  logic  npc_sel,         // branch or jump redirect pulse from execute
  input  addr_t brj_addr,
  input  logic  insert_priv_pc,  // trap or return redirect pulse, wins over a branch
  input  addr_t priv_pc,
  input  logic  if_ex_stall_in,  // execute back-pressure
  input  logic  if_ex_flush_in,  // execute kills whatever fetch hands over
  output logic  pc_en,
  output logic  pc_sel,
  output addr_t redirect_pc,
  output logic  if_ex_stall,
  output logic  if_ex_flush
);

  logic  pend_valid;  // a redirect is waiting for the pc
  logic  pend_priv;   // the waiting redirect came from the privileged side
  addr_t pend_pc;
  logic  nxt_valid;   // pending state including a pulse arriving this cycle
  logic  nxt_priv;
  addr_t nxt_pc;

  // a privileged pulse always replaces what is waiting, a branch pulse only
  // replaces another branch since a pending trap target must not be lost
  always_comb begin
    nxt_valid = pend_valid | insert_priv_pc | npc_sel;
    nxt_priv  = pend_priv;
    nxt_pc    = pend_pc;
    if (insert_priv_pc) begin
      nxt_priv = 1'b1;
      nxt_pc   = priv_pc;
    end else if (npc_sel && !pend_priv) begin
      nxt_priv = 1'b0;
      nxt_pc   = brj_addr;
    end
  end

  // the pc moves when a word is accepted, or straight away for a redirect
  // when no read is out on the bus, otherwise the redirect waits for the ack
  assign pc_en = !if_ex_stall_in && !if_ex_flush_in &&
                 (fetch_ack || (!fetch_busy && nxt_valid));

  assign pc_sel      = nxt_valid;
  assign redirect_pc = nxt_pc;

  // the redirect is consumed on the edge where the pc takes it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pend_valid <= 1'b0;
      pend_priv  <= 1'b0;
      pend_pc    <= '0;
    end else if (pc_en) begin
      pend_valid <= 1'b0;
      pend_priv  <= 1'b0;
    end else begin
      pend_valid <= nxt_valid;
      pend_priv  <= nxt_priv;
      pend_pc    <= nxt_pc;
    end
  end

  assign if_ex_stall = if_ex_stall_in;

  // bubble when there is no word, or the word belongs to the path being left
  assign if_ex_flush = if_ex_flush_in | (!if_ex_stall_in & (!fetch_ack | nxt_valid));

endmodule

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor import rv32i_fetch_pkg::*; #(
  parameter int BTB_ENTRIES = 16  // has to match the width of btb_idx_t
) (
  input  logic  CLK,
  input  logic  nRST,
  input  addr_t lookup_pc,       // pc currently being fetched
  input  logic  upd_en,          // execute resolved a branch or jump this cycle
  input  addr_t upd_pc,          // address of the resolved branch
  input  logic  upd_taken,       // actual outcome
  input  addr_t upd_target,      // actual target, kept even when not taken
  output logic  predict_taken,
  output addr_t predict_target
);

  // entry storage, only the valid bits need a defined value after reset
  logic        btb_valid  [BTB_ENTRIES];
  btb_tag_t    btb_tag    [BTB_ENTRIES];
  addr_t       btb_target [BTB_ENTRIES];
  pred_state_t btb_state  [BTB_ENTRIES];

  btb_idx_t    lk_idx;     // lookup side index
  btb_tag_t    lk_tag;
  btb_idx_t    upd_idx;    // training side index
  btb_tag_t    upd_tag;
  logic        upd_hit;    // the trained branch already owns its entry
  pred_state_t upd_state;  // counter value written back on training

  assign lk_idx  = lookup_pc[5:2];
  assign lk_tag  = lookup_pc[31:6];
  assign upd_idx = upd_pc[5:2];
  assign upd_tag = upd_pc[31:6];

  // lookup is purely combinational so fetch can use the target at the same ack
  // a taken prediction needs a live entry, a full tag match and the counter msb set
  assign predict_taken  = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag) &&
                          (btb_state[lk_idx] inside {weak_t, strong_t});
  assign predict_target = btb_target[lk_idx];

  assign upd_hit = btb_valid[upd_idx] && (btb_tag[upd_idx] == upd_tag);

  // counter update, a miss allocates in a weak state, a hit moves one step
  always_comb begin
    upd_state = btb_state[upd_idx];
    if (!upd_hit) begin
      upd_state = upd_taken ? weak_t : weak_nt;  // new owner of the entry
    end else if (upd_taken) begin
      case (btb_state[upd_idx])
        strong_nt: upd_state = weak_nt;
        weak_nt:   upd_state = weak_t;
        default:   upd_state = strong_t;  // weak_t and strong_t saturate at the top
      endcase
    end else begin
      case (btb_state[upd_idx])
        strong_t: upd_state = weak_t;
        weak_t:   upd_state = weak_nt;
        default:  upd_state = strong_nt;  // weak_nt and strong_nt saturate at the bottom
      endcase
    end
  end

  // valid bits, all entries start empty
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_valid[i] <= 1'b0;
      end
    end else if (upd_en) begin
      btb_valid[upd_idx] <= 1'b1;  // a miss takes the entry over, a hit keeps it
    end
  end

  // tag, target and counter are plain storage behind the valid bit
  always_ff @(posedge CLK) begin
    if (upd_en) begin
      btb_tag[upd_idx]    <= upd_tag;
      btb_target[upd_idx] <= upd_target;  // a hit still refreshes the target
      btb_state[upd_idx]  <= upd_state;
    end
  end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import rv32i_fetch_pkg::*; #(
  parameter addr_t RESET_PC = 32'h200  // first fetch address after reset
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  pc_en,           // hazard unit lets the pc move this cycle
  input  logic  pc_sel,          // redirect_pc beats the prediction and pc plus four
  input  addr_t redirect_pc,     // branch or privileged target, already arbitrated
  input  logic  predict_taken,   // btb hit on the current pc with a taken counter
  input  addr_t predict_target,
  input  logic  fetch_ack,       // fetch_data holds the word for the current pc
  input  word_t fetch_data,      // little endian, straight from the bus master
  input  logic  if_ex_stall,     // execute cannot take a new instruction
  input  logic  if_ex_flush,     // load a bubble instead of the word
  output addr_t fetch_addr,      // address the bus master reads from
  output addr_t lookup_pc,       // btb lookup address, same as the fetch address
  output logic  token,
  output addr_t ex_pc,
  output addr_t ex_pc4,
  output word_t ex_instr,
  output logic  ex_prediction,
  output logic  mal_insn,        // the pc is not word aligned
  output addr_t badaddr_f,       // faulting address for the trap handler
  output addr_t epc_f            // pc of the faulting fetch
);

  addr_t pc;     // address of the word being fetched now
  addr_t pc4;    // sequential successor
  addr_t npc;    // pc after the next pc_en
  word_t instr;  // fetch_data in big endian order

  // the pc only moves on an accepted fetch or on a redirect while the bus is idle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  assign pc4 = pc + 32'd4;

  // a redirect from execute or the csr side outranks anything the btb says
  assign npc = pc_sel        ? redirect_pc    :
               predict_taken ? predict_target :
                               pc4;

  assign fetch_addr = pc;
  assign lookup_pc  = pc;  // the btb answers in the same cycle so the hit is ready at ack

  // memory is little endian, the decoder expects the most significant byte first
  assign instr = {fetch_data[7:0], fetch_data[15:8], fetch_data[23:16], fetch_data[31:24]};

  // control half of the fetch/execute register, a flush or a cycle without ack
  // leaves token low so execute sees a bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      token         <= 1'b0;
      ex_prediction <= 1'b0;
    end else if (if_ex_flush) begin
      token         <= 1'b0;  // bubble, the rest of the register is don't care
      ex_prediction <= 1'b0;
    end else if (!if_ex_stall) begin
      token         <= fetch_ack;
      ex_prediction <= fetch_ack & predict_taken;  // only meaningful alongside a real word
    end
  end

  // payload half, only written when a word is actually handed over
  // during a stall it keeps the instruction execute is still working on
  always_ff @(posedge CLK) begin
    if (fetch_ack && !if_ex_stall) begin
      ex_pc    <= pc;
      ex_pc4   <= pc4;
      ex_instr <= instr;
    end
  end

  // rv32i without the c extension traps on any pc that is not a multiple of four
  assign mal_insn  = (pc[1:0] != 2'b00);
  assign badaddr_f = pc;  // the offending address is the pc itself
  assign epc_f     = pc;  // handler returns to the same fetch

endmodule

// ==== logic/rv32i_fetch_pkg.sv ====
package rv32i_fetch_pkg;

  // every quantity on the fetch path is a plain 32-bit vector, the names
  // only say what the bits mean at a given port
  typedef logic [31:0] word_t;  // one instruction or data word as stored in memory
  typedef logic [31:0] addr_t;  // byte address, legal for fetch only when bits [1:0] are zero

  // the btb is direct mapped with 16 entries
  // pc[1:0] is always zero for a legal fetch so the index starts at bit 2
  typedef logic [3:0]  btb_idx_t;  // pc[5:2], picks the entry
  typedef logic [25:0] btb_tag_t;  // pc[31:6], whatever the index leaves over

  // two-bit saturating counter kept per btb entry
  // the msb alone decides the prediction, the lsb is the hysteresis bit
  // training walks one step at a time toward strong_t or strong_nt
  typedef enum logic [1:0] {
    strong_nt = 2'b00,  // seen not taken at least twice in a row
    weak_nt   = 2'b01,  // leaning not taken, one taken outcome flips it
    weak_t    = 2'b10,  // leaning taken, one not taken outcome flips it
    strong_t  = 2'b11   // seen taken at least twice in a row
  } pred_state_t;

  // a fresh entry always starts in one of the weak states so that a
  // single opposite outcome is enough to change its mind

  // pipeline register contents as seen by execute
  // token  marks a real instruction, zero for a bubble
  // pc     address the word was fetched from
  // pc4    pc plus four, the link value for jal and jalr
  // instr  the fetched word, byte reversed
  // prediction  the btb said taken for this pc

endpackage
